//--- src/huff_pkg.sv
`default_nettype none

package huff_pkg;

    // Table layout
    parameter int NUM_SYM     = 128;  // Symbol entries, also base of node entries
    parameter int TABLE_DEPTH = 256;

    typedef logic [31:0] weight_t;    // Count or merged node weight
    typedef logic [7:0]  tidx_t;      // Table index, bit 7 set for nodes
    typedef logic [6:0]  sym_t;       // Input symbol
    typedef logic [6:0]  node_num_t;  // Merged node number

    typedef enum logic [1:0] {
        PH_COUNT,  // Histogram of incoming symbols
        PH_SCAN,   // Waiting for the finder
        PH_MERGE,  // Merge write and node record
        PH_DONE    // Root reported, table cleared
    } build_phase_t;

endpackage

`default_nettype wire

//--- src/huff_weight_table.sv
`timescale 1ns/1ns
`default_nettype none

module huff_weight_table import huff_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    inc_en,
    input  sym_t    inc_sym,
    input  logic    merge_en,
    input  tidx_t   merge_clr1,
    input  tidx_t   merge_clr2,
    input  tidx_t   merge_index,
    input  weight_t merge_weight,
    input  logic    clear_all,
    input  tidx_t   rd_index,
    output weight_t rd_weight
);

    weight_t weights [TABLE_DEPTH];

    tidx_t inc_index;

    assign inc_index = {1'b0, inc_sym};  // Symbols live in the lower half

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                weights[i] <= '0;
            end
        end else if (clear_all) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                weights[i] <= '0;
            end
        end else begin
            if (inc_en) begin
                weights[inc_index] <= weights[inc_index] + weight_t'(1);
            end
            // Both children leave the table as the parent enters it
            if (merge_en) begin
                weights[merge_clr1]  <= '0;
                weights[merge_clr2]  <= '0;
                weights[merge_index] <= merge_weight;
            end
        end
    end

    assign rd_weight = weights[rd_index];  // Read in the same cycle

    // Merged nodes must never overwrite a symbol count
    a_merge_in_node_half: assert property (
        @(posedge clk) disable iff (rst)
        merge_en |-> (int'(merge_index) >= NUM_SYM)
    );

endmodule

`default_nettype wire

//--- src/huff_least_finder.sv
`timescale 1ns/1ns
`default_nettype none

module huff_least_finder import huff_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    scan_start,
    output tidx_t   rd_index,
    input  weight_t rd_weight,
    output logic    scan_done,
    output logic    pair_valid,
    output logic    single_valid,
    output tidx_t   least1,
    output tidx_t   least2,
    output weight_t pair_sum
);

    logic    active;
    logic    last_read;
    weight_t val1;
    weight_t val2;
    weight_t val1_n;
    weight_t val2_n;
    tidx_t   least1_n;
    tidx_t   least2_n;

    assign last_read = active && (rd_index == tidx_t'(TABLE_DEPTH - 1));

    // Running two-least update, strict less-than keeps the lower index on ties
    always_comb begin
        val1_n   = val1;
        val2_n   = val2;
        least1_n = least1;
        least2_n = least2;
        if (active && rd_weight != '0) begin
            if (rd_weight < val1) begin
                val2_n   = val1;      // Old minimum slides down
                least2_n = least1;
                val1_n   = rd_weight;
                least1_n = rd_index;
            end else if (rd_weight < val2) begin
                val2_n   = rd_weight;
                least2_n = rd_index;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active       <= 1'b0;
            rd_index     <= '0;
            scan_done    <= 1'b0;
            pair_valid   <= 1'b0;
            single_valid <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (scan_start) begin
                active       <= 1'b1;
                rd_index     <= '0;
                pair_valid   <= 1'b0;
                single_valid <= 1'b0;
            end else if (active) begin
                rd_index <= rd_index + tidx_t'(1);
                if (last_read) begin
                    active       <= 1'b0;
                    scan_done    <= 1'b1;
                    pair_valid   <= (val2_n != '1);
                    single_valid <= (val1_n != '1) && (val2_n == '1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_start) begin
            val1 <= '1;  // Seed above any reachable weight
            val2 <= '1;
        end else begin
            val1   <= val1_n;
            val2   <= val2_n;
            least1 <= least1_n;
            least2 <= least2_n;
            if (last_read) begin
                pair_sum <= val1_n + val2_n;
            end
        end
    end

    a_pair_distinct: assert property (
        @(posedge clk) disable iff (rst)
        pair_valid |-> (least1 != least2)
    );

endmodule

`default_nettype wire

//--- src/huff_tree_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module huff_tree_ctrl import huff_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sym_valid,
    input  sym_t    sym,
    input  logic    build,
    output logic    inc_en,
    output sym_t    inc_sym,
    output logic    scan_start,
    input  logic    scan_done,
    input  logic    pair_valid,
    input  logic    single_valid,
    input  tidx_t   least1,
    input  tidx_t   least2,
    input  weight_t pair_sum,
    output logic    merge_en,
    output tidx_t   merge_index,
    output logic    clear_all,
    output logic    node_valid,
    output tidx_t   node_index,
    output tidx_t   left_index,
    output tidx_t   right_index,
    output weight_t node_weight,
    output logic    tree_done,
    output logic    root_valid,
    output tidx_t   root_index
);

    build_phase_t state;
    node_num_t    node_cnt;
    logic         scan_end;

    assign inc_en   = sym_valid && (state == PH_COUNT);  // Counting only between builds
    assign inc_sym  = sym;
    assign scan_end = (state == PH_SCAN) && scan_done;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= PH_COUNT;
            node_cnt   <= '0;
            scan_start <= 1'b0;
            node_valid <= 1'b0;
            tree_done  <= 1'b0;
            root_valid <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            node_valid <= 1'b0;
            tree_done  <= 1'b0;
            case (state)
                PH_COUNT: begin
                    if (build) begin
                        scan_start <= 1'b1;
                        state      <= PH_SCAN;
                    end
                end
                PH_SCAN: begin
                    if (scan_done && pair_valid) begin
                        node_valid <= 1'b1;
                        state      <= PH_MERGE;
                    end else if (scan_done) begin
                        tree_done  <= 1'b1;
                        root_valid <= single_valid;  // Empty table has no root
                        state      <= PH_DONE;
                    end
                end
                PH_MERGE: begin
                    node_cnt   <= node_cnt + node_num_t'(1);
                    scan_start <= 1'b1;
                    state      <= PH_SCAN;
                end
                default: begin
                    node_cnt <= '0;
                    state    <= PH_COUNT;
                end
            endcase
        end
    end

    // Node record and root, qualified by their strobes
    always_ff @(posedge clk) begin
        if (scan_end) begin
            node_index  <= tidx_t'(NUM_SYM + int'(node_cnt));
            left_index  <= least1;
            right_index <= least2;
            node_weight <= pair_sum;
            root_index  <= least1;
        end
    end

    assign merge_en    = node_valid;
    assign merge_index = node_index;
    assign clear_all   = (state == PH_DONE);  // Table ready for the next message

    // 128 symbols give at most 127 merges
    a_node_cnt_range: assert property (
        @(posedge clk) disable iff (rst)
        (scan_end && pair_valid) |-> (node_cnt != node_num_t'(127))
    );

endmodule

`default_nettype wire

//--- src/huff_tree_builder.sv
`timescale 1ns/1ns
`default_nettype none

module huff_tree_builder import huff_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sym_valid,
    input  sym_t    sym,
    input  logic    build,
    output logic    node_valid,
    output tidx_t   node_index,
    output tidx_t   left_index,
    output tidx_t   right_index,
    output weight_t node_weight,
    output logic    tree_done,
    output logic    root_valid,
    output tidx_t   root_index
);

    logic    inc_en;
    sym_t    inc_sym;
    logic    merge_en;
    tidx_t   merge_index;
    logic    clear_all;
    tidx_t   rd_index;
    weight_t rd_weight;
    logic    scan_start;
    logic    scan_done;
    logic    pair_valid;
    logic    single_valid;
    tidx_t   least1;
    tidx_t   least2;
    weight_t pair_sum;

    huff_weight_table u_table (
        .clk          (clk),
        .rst          (rst),
        .inc_en       (inc_en),
        .inc_sym      (inc_sym),
        .merge_en     (merge_en),
        .merge_clr1   (least1),
        .merge_clr2   (least2),
        .merge_index  (merge_index),
        .merge_weight (pair_sum),
        .clear_all    (clear_all),
        .rd_index     (rd_index),
        .rd_weight    (rd_weight)
    );

    huff_least_finder u_finder (
        .clk          (clk),
        .rst          (rst),
        .scan_start   (scan_start),
        .rd_index     (rd_index),
        .rd_weight    (rd_weight),
        .scan_done    (scan_done),
        .pair_valid   (pair_valid),
        .single_valid (single_valid),
        .least1       (least1),
        .least2       (least2),
        .pair_sum     (pair_sum)
    );

    huff_tree_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .sym_valid    (sym_valid),
        .sym          (sym),
        .build        (build),
        .inc_en       (inc_en),
        .inc_sym      (inc_sym),
        .scan_start   (scan_start),
        .scan_done    (scan_done),
        .pair_valid   (pair_valid),
        .single_valid (single_valid),
        .least1       (least1),
        .least2       (least2),
        .pair_sum     (pair_sum),
        .merge_en     (merge_en),
        .merge_index  (merge_index),
        .clear_all    (clear_all),
        .node_valid   (node_valid),
        .node_index   (node_index),
        .left_index   (left_index),
        .right_index  (right_index),
        .node_weight  (node_weight),
        .tree_done    (tree_done),
        .root_valid   (root_valid),
        .root_index   (root_index)
    );

endmodule

`default_nettype wire

//--- verification/huff_tree_model.svh
`ifndef HUFF_TREE_MODEL_SVH
`define HUFF_TREE_MODEL_SVH

weight_t m_weights [TABLE_DEPTH];
tidx_t   exp_node [$];
tidx_t   exp_left [$];
tidx_t   exp_right [$];
weight_t exp_weight [$];
logic    exp_root_valid;
tidx_t   exp_root_index;

function automatic void model_clear();
    for (int i = 0; i < TABLE_DEPTH; i++) begin
        m_weights[i] = '0;
    end
endfunction

function automatic void model_count(sym_t s);
    m_weights[s] = m_weights[s] + 1;
endfunction

// Lowest index holding the least nonzero weight, one index excluded
function automatic int find_least(int skip);
    int best;
    best = -1;
    for (int i = 0; i < TABLE_DEPTH; i++) begin
        if (i != skip && m_weights[i] != 0) begin
            if (best < 0 || m_weights[i] < m_weights[best]) begin
                best = i;
            end
        end
    end
    return best;
endfunction

// Full merge sequence, leaves the table empty like the DUT
function automatic void model_build();
    int a;
    int b;
    int k;
    weight_t sum;
    exp_node.delete();
    exp_left.delete();
    exp_right.delete();
    exp_weight.delete();
    k = 0;
    a = find_least(-1);
    b = (a < 0) ? -1 : find_least(a);
    while (b >= 0) begin
        sum = m_weights[a] + m_weights[b];
        exp_node.push_back(tidx_t'(NUM_SYM + k));
        exp_left.push_back(tidx_t'(a));
        exp_right.push_back(tidx_t'(b));
        exp_weight.push_back(sum);
        m_weights[a] = '0;
        m_weights[b] = '0;
        m_weights[NUM_SYM + k] = sum;
        k++;
        a = find_least(-1);
        b = (a < 0) ? -1 : find_least(a);
    end
    exp_root_valid = (a >= 0);
    exp_root_index = (a >= 0) ? tidx_t'(a) : '0;
    model_clear();
endfunction

`endif

//--- verification/huff_tree_builder_tb.sv
`timescale 1ns/1ns
`default_nettype none

module huff_tree_builder_tb import huff_pkg::*; ();

    logic    clk;
    logic    rst;
    logic    sym_valid;
    sym_t    sym;
    logic    build;
    logic    node_valid;
    tidx_t   node_index;
    tidx_t   left_index;
    tidx_t   right_index;
    weight_t node_weight;
    logic    tree_done;
    logic    root_valid;
    tidx_t   root_index;

    `include "huff_tree_model.svh"

    integer  seed;
    int      errors;
    int      tests_run;
    int      tests_failed;
    int      test_err_start;
    int      done_cnt;
    int      done_mark;
    tidx_t   got_node [$];
    tidx_t   got_left [$];
    tidx_t   got_right [$];
    weight_t got_weight [$];
    logic    got_root_valid;
    tidx_t   got_root_index;

    huff_tree_builder dut0 (
        .clk         (clk),
        .rst         (rst),
        .sym_valid   (sym_valid),
        .sym         (sym),
        .build       (build),
        .node_valid  (node_valid),
        .node_index  (node_index),
        .left_index  (left_index),
        .right_index (right_index),
        .node_weight (node_weight),
        .tree_done   (tree_done),
        .root_valid  (root_valid),
        .root_index  (root_index)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (node_valid === 1'b1) begin
            got_node.push_back(node_index);
            got_left.push_back(left_index);
            got_right.push_back(right_index);
            got_weight.push_back(node_weight);
        end
        if (tree_done === 1'b1) begin
            done_cnt++;
            got_root_valid = root_valid;
            got_root_index = root_index;
        end
    end

    task automatic check_hex(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
            errors++;
        end
    endtask

    task automatic send_sym(input sym_t s, input bit counted);
        sym_valid = 1'b1;
        sym = s;
        if (counted) begin
            model_count(s);
        end
        @(posedge clk);
        #2;
        sym_valid = 1'b0;
    endtask

    task automatic clear_capture();
        got_node.delete();
        got_left.delete();
        got_right.delete();
        got_weight.delete();
    endtask

    task automatic start_build();
        clear_capture();
        model_build();
        build = 1'b1;
        @(posedge clk);
        #2;
        build = 1'b0;
    endtask

    task automatic finish_build();
        int start;
        int cycles;
        start = done_cnt;
        cycles = 0;
        while (done_cnt == start && cycles < 40000) begin
            @(posedge clk);
            cycles++;
        end
        #2;
        assert (done_cnt != start) else begin
            $display("Timeout: tree_done did not arrive within 40000 cycles");
            errors++;
        end
        check_hex("node count", got_node.size(), exp_node.size());
        for (int i = 0; i < exp_node.size() && i < got_node.size(); i++) begin
            check_hex("node_index", got_node[i], exp_node[i]);
            check_hex("left_index", got_left[i], exp_left[i]);
            check_hex("right_index", got_right[i], exp_right[i]);
            check_hex("node_weight", got_weight[i], exp_weight[i]);
        end
        check_hex("root_valid", got_root_valid, exp_root_valid);
        if (exp_root_valid) begin
            check_hex("root_index", got_root_index, exp_root_index);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > test_err_start) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name,
                 (errors > test_err_start) ? "failed" : "ok");
        test_err_start = errors;
    endtask

    initial begin
        seed = 87046;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err_start = 0;
        done_cnt = 0;
        rst = 1'b1;
        sym_valid = 1'b0;
        sym = '0;
        build = 1'b0;
        model_clear();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (200) send_sym(sym_t'($random(seed) & 15), 1'b1);
        start_build();
        finish_build();
        if (got_weight.size() > 0) begin
            check_hex("root weight", got_weight[got_weight.size() - 1], 200);
        end
        end_test("random message");

        repeat (2) begin
            send_sym(7'd7, 1'b1);
            send_sym(7'd5, 1'b1);
        end
        repeat (3) begin
            send_sym(7'd40, 1'b1);
            send_sym(7'd10, 1'b1);
            send_sym(7'd30, 1'b1);
        end
        send_sym(7'd61, 1'b1);
        send_sym(7'd60, 1'b1);
        start_build();
        finish_build();
        if (got_left.size() > 1) begin
            check_hex("first left_index", got_left[0], 60);  // Equal counts, lower index first
            check_hex("second right_index", got_right[1], 7);
        end
        end_test("tie ordering");

        repeat (9) send_sym(7'd42, 1'b1);
        start_build();
        finish_build();
        check_hex("single root_index", got_root_index, 42);
        end_test("single symbol");

        start_build();
        finish_build();
        end_test("empty message");

        repeat (30) send_sym(sym_t'($random(seed) & 63), 1'b1);
        start_build();
        repeat (5) send_sym(sym_t'($random(seed) & 63), 1'b0);  // Dropped while scanning
        finish_build();
        repeat (40) send_sym(sym_t'($random(seed) & 63), 1'b1);
        start_build();
        finish_build();
        end_test("symbols during build");

        repeat (60) send_sym(sym_t'($random(seed) & 31), 1'b1);
        start_build();
        repeat (400) @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        clear_capture();
        done_mark = done_cnt;
        repeat (1000) @(posedge clk);
        #2;
        check_hex("strobes after reset", got_node.size() + done_cnt - done_mark, 0);
        repeat (100) send_sym(sym_t'($random(seed) & 31), 1'b1);
        start_build();
        finish_build();
        end_test("reset during build");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- huff_tree_builder.f
+incdir+verification
src/huff_pkg.sv
src/huff_weight_table.sv
src/huff_least_finder.sv
src/huff_tree_ctrl.sv
src/huff_tree_builder.sv
verification/huff_tree_builder_tb.sv

//--- Bender.yml
package:
  name: huff_tree_builder

sources:
  - files:
      - src/huff_pkg.sv
      - src/huff_weight_table.sv
      - src/huff_least_finder.sv
      - src/huff_tree_ctrl.sv
      - src/huff_tree_builder.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/huff_tree_builder_tb.sv
